// File: list.f
rtl/mmp_pkg.sv
rtl/stage_ctrl.sv
rtl/packet_entry_stage.sv
rtl/mmram_stage.sv
rtl/packet_formatter.sv
rtl/mmp_top.sv
verification/tb_clock_gen.sv
verification/mmp_checker.sv
verification/tb_mmp.sv

// File: rtl/mmp_pkg.sv
package mmp_pkg;

    // field widths
    localparam int DATA_W = 20;
    localparam int DEST_W = 7;
    localparam int TAG_W  = 11;
    localparam int RD_W   = 16;

    // field positions inside the 38-bit input packet
    localparam int DEST_LSB     = DATA_W;
    localparam int TAG_LSB      = DEST_LSB + DEST_W;
    localparam int MEM_FLAG_BIT = 18;

    localparam int PKT_IN_W  = TAG_LSB + TAG_W;
    localparam int PKT_OUT_W = 52;

    // latched packet followed by the read value
    localparam int MERGE_W = PKT_IN_W + RD_W;

    // operand RAM
    localparam int MEM_DEPTH = 64;
    localparam int ADDR_W    = $clog2(MEM_DEPTH);

    // same 54-bit word, two decodings chosen by lr
    typedef union packed {
        // lr = 1: read value goes above the low data bits
        struct packed {
            logic              lr;
            logic [TAG_W-2:0]  tag_lo;
            logic [DEST_W-1:0] dest;
            logic              data_msb;
            logic [DATA_W-2:0] data_lo;
            logic [RD_W-1:0]   rd;
        } lr_view;
        // lr = 0: full data, read value loses its top bit
        struct packed {
            logic              lr;
            logic [TAG_W-2:0]  tag_lo;
            logic [DEST_W-1:0] dest;
            logic [DATA_W-1:0] data;
            logic              rd_msb;
            logic [RD_W-2:0]   rd_lo;
        } cz_view;
    } merge_word_u;

    // constant table, entry n holds n + 1
    // only the low six bits of dest index the table
    function automatic logic [RD_W-1:0] const_entry(input logic [DEST_W-1:0] dest);
        logic [RD_W-1:0] idx;
        idx = {{(RD_W - ADDR_W){1'b0}}, dest[ADDR_W-1:0]};
        return idx + 1'b1;
    endfunction

endpackage

// File: rtl/mmp_top.sv
module mmp_top (
    input  logic                          CP,
    input  logic                          MR,
    input  logic                          in_send,
    input  logic                          in_wr_e,
    input  logic                          in_del,
    input  logic [mmp_pkg::ADDR_W-1:0]    in_addr,
    input  logic [mmp_pkg::PKT_IN_W-1:0]  in_packet,
    input  logic                          out_ack,
    output logic                          in_ack,
    output logic                          out_send,
    output logic [mmp_pkg::PKT_OUT_W-1:0] out_packet
);

    import mmp_pkg::*;

    // entry stage to matching-memory stage
    logic                mid_send;
    logic                mid_ack;
    logic [PKT_IN_W-1:0] mid_packet;
    logic                mid_wr_e;
    logic [ADDR_W-1:0]   mid_addr;
    logic                mid_del;

    merge_word_u merged;

    packet_entry_stage entry_inst (
        .CP         (CP),
        .MR         (MR),
        .send_in    (in_send),
        .ack_in     (mid_ack),
        .packet_in  (in_packet),
        .wr_e_in    (in_wr_e),
        .addr_in    (in_addr),
        .del_in     (in_del),
        .send_out   (mid_send),
        .ack_out    (in_ack),
        .packet_out (mid_packet),
        .wr_e_out   (mid_wr_e),
        .addr_out   (mid_addr),
        .del_out    (mid_del)
    );

    mmram_stage mmram_inst (
        .CP        (CP),
        .MR        (MR),
        .send_in   (mid_send),
        .ack_in    (out_ack),
        .wr_e      (mid_wr_e),
        .del       (mid_del),
        .addr      (mid_addr),
        .packet_in (mid_packet),
        .send_out  (out_send),
        .ack_out   (mid_ack),
        .merged    (merged)
    );

    // output packet follows the merged word combinationally
    packet_formatter fmt_inst (
        .merged     (merged),
        .packet_out (out_packet)
    );

endmodule

// File: rtl/mmram_stage.sv
module mmram_stage (
    input  logic                         CP,
    input  logic                         MR,
    input  logic                         send_in,
    input  logic                         ack_in,
    input  logic                         wr_e,
    input  logic                         del,
    input  logic [mmp_pkg::ADDR_W-1:0]   addr,
    input  logic [mmp_pkg::PKT_IN_W-1:0] packet_in,
    output logic                         send_out,
    output logic                         ack_out,
    output mmp_pkg::merge_word_u         merged
);

    import mmp_pkg::*;

    logic                fire;
    logic [PKT_IN_W-1:0] pkt_q;
    logic [DATA_W-1:0]   ram [MEM_DEPTH];
    logic [RD_W-1:0]     ram_q;
    logic [RD_W-1:0]     cst_q;
    logic [RD_W-1:0]     rd_sel;
    logic [MERGE_W-1:0]  merge_raw;

    stage_ctrl ctrl_inst (
        .CP       (CP),
        .MR       (MR),
        .send_in  (send_in),
        .ack_in   (ack_in),
        .del      (del),
        .send_out (send_out),
        .ack_out  (ack_out),
        .fire     (fire)
    );

    // data latch
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            pkt_q <= '0;
        end else if (fire) begin
            pkt_q <= packet_in;
        end
    end

    // operand RAM is written even for a deleted packet
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                ram[i] <= '0;
            end
        end else if (fire && wr_e) begin
            ram[addr] <= packet_in[DATA_W-1:0];
        end
    end

    // registered reads
    // same-packet write shows the old word here
    // only the low 16 RAM bits reach the merged word
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            ram_q <= '0;
            cst_q <= '0;
        end else if (fire) begin
            ram_q <= ram[addr][RD_W-1:0];
            cst_q <= const_entry(packet_in[DEST_LSB +: DEST_W]);
        end
    end

    // mem_flag of the latched packet picks RAM or constant
    assign rd_sel = pkt_q[MEM_FLAG_BIT] ? ram_q : cst_q;

    assign merge_raw = {pkt_q, rd_sel};
    assign merged    = merge_raw;

    // a write needs a clean address
    wr_addr_known_a: assert property (
        @(posedge CP) disable iff (MR)
        (fire && wr_e) |-> !$isunknown(addr)
    ) else $error("RAM write with unknown address");

endmodule

// File: rtl/packet_entry_stage.sv
module packet_entry_stage (
    input  logic                         CP,
    input  logic                         MR,
    input  logic                         send_in,
    input  logic                         ack_in,
    input  logic [mmp_pkg::PKT_IN_W-1:0] packet_in,
    input  logic                         wr_e_in,
    input  logic [mmp_pkg::ADDR_W-1:0]   addr_in,
    input  logic                         del_in,
    output logic                         send_out,
    output logic                         ack_out,
    output logic [mmp_pkg::PKT_IN_W-1:0] packet_out,
    output logic                         wr_e_out,
    output logic [mmp_pkg::ADDR_W-1:0]   addr_out,
    output logic                         del_out
);

    import mmp_pkg::*;

    logic fire;

    // delete is carried forward, never acted on here
    stage_ctrl ctrl_inst (
        .CP       (CP),
        .MR       (MR),
        .send_in  (send_in),
        .ack_in   (ack_in),
        .del      (1'b0),
        .send_out (send_out),
        .ack_out  (ack_out),
        .fire     (fire)
    );

    // packet and side-band controls held steady for the next stage
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            packet_out <= '0;
            wr_e_out   <= 1'b0;
            addr_out   <= '0;
            del_out    <= 1'b0;
        end else if (fire) begin
            packet_out <= packet_in;
            wr_e_out   <= wr_e_in;
            addr_out   <= addr_in;
            del_out    <= del_in;
        end
    end

endmodule

// File: rtl/packet_formatter.sv
module packet_formatter (
    input  mmp_pkg::merge_word_u          merged,
    output logic [mmp_pkg::PKT_OUT_W-1:0] packet_out
);

    // lr picks which decoding of the merged word is sent out
    always_comb begin
        if (merged.lr_view.lr) begin
            // tag, dest, read value, data without its top bit
            packet_out = {
                merged.lr_view.tag_lo,
                merged.lr_view.dest,
                merged.lr_view.rd,
                merged.lr_view.data_lo
            };
        end else begin
            // tag, dest, full data, read value without its top bit
            packet_out = {
                merged.cz_view.tag_lo,
                merged.cz_view.dest,
                merged.cz_view.data,
                merged.cz_view.rd_lo
            };
        end
    end

endmodule

// File: rtl/stage_ctrl.sv
module stage_ctrl (
    input  logic CP,
    input  logic MR,
    input  logic send_in,
    input  logic ack_in,
    input  logic del,
    output logic send_out,
    output logic ack_out,
    output logic fire
);

    // stage holds a packet
    logic full;

    // accept when empty, or when the held packet leaves this cycle
    assign fire = send_in && (!full || ack_in);

    // taking a packet is the acknowledge upstream
    assign ack_out = fire;

    assign send_out = full;

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            full <= 1'b0;
        end else if (fire) begin
            // a deleted packet is consumed here
            full <= !del;
        end else if (ack_in) begin
            full <= 1'b0;
        end
    end

    // downstream must have taken the packet before send drops
    send_hold_a: assert property (
        @(posedge CP) disable iff (MR)
        $fell(send_out) |-> $past(ack_in)
    ) else $error("send_out dropped without ack_in");

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mmp -f list.f -Mdir obj_dir -o tb_mmp
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mmp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: verification/mmp_checker.sv
module mmp_checker (
    input  logic                          CP,
    input  logic                          MR,
    input  logic                          in_send,
    input  logic                          in_ack,
    input  logic                          in_wr_e,
    input  logic                          in_del,
    input  logic [mmp_pkg::ADDR_W-1:0]    in_addr,
    input  logic [mmp_pkg::PKT_IN_W-1:0]  in_packet,
    input  logic [mmp_pkg::RD_W-1:0]      in_exp_rd,
    input  logic                          out_send,
    input  logic                          out_ack,
    input  logic [mmp_pkg::PKT_OUT_W-1:0] out_packet,
    input  logic                          done,
    output int                            error_count,
    output int                            compare_count,
    output int                            pending
);

    import mmp_pkg::*;

    logic [DATA_W-1:0]    model_ram [MEM_DEPTH];
    logic [PKT_OUT_W-1:0] expected_q [$];
    logic [PKT_OUT_W-1:0] held_packet;
    logic [PKT_OUT_W-1:0] exp_packet;
    logic [RD_W-1:0]      model_rd;
    logic                 stalled = 1'b0;
    logic                 done_seen = 1'b0;
    int                   errors = 0;
    int                   compares = 0;
    int                   queued = 0;

    assign error_count   = errors;
    assign compare_count = compares;
    assign pending       = queued;

    // entry n holds n + 1 and dest wraps every 64 entries
    function automatic logic [RD_W-1:0] const_lookup(input logic [DEST_W-1:0] dest);
        int entry;
        entry = dest % 64;
        return RD_W'(entry + 1);
    endfunction

    // lr set drops data bit 19 and lr clear drops read bit 15
    function automatic logic [PKT_OUT_W-1:0] format_packet(
        input logic [PKT_IN_W-1:0] pkt,
        input logic [RD_W-1:0]     rd
    );
        logic [9:0]  tag_lo;
        logic [6:0]  dest;
        logic [19:0] data;
        tag_lo = pkt[36:27];
        dest   = pkt[26:20];
        data   = pkt[19:0];
        if (pkt[37]) begin
            return {tag_lo, dest, rd, data[18:0]};
        end
        return {tag_lo, dest, data, rd[14:0]};
    endfunction

    always @(posedge CP) begin
        if (MR) begin
            for (int k = 0; k < MEM_DEPTH; k++) begin
                model_ram[k] = '0;
            end
            expected_q.delete();
            stalled = 1'b0;
        end else begin
            // output side is checked before a new packet is queued
            if (stalled) begin
                if (!out_send) begin
                    $display("out_send dropped at %0t while out_ack was low", $time);
                    errors++;
                end else if (out_packet !== held_packet) begin
                    $display("error at %0t: out_packet changed during stall, %h was %h",
                             $time, out_packet, held_packet);
                    errors++;
                end
            end
            if (out_send && expected_q.size() == 0) begin
                $display("out_send high at %0t with no packet in flight", $time);
                errors++;
            end else if (out_send && out_ack) begin
                exp_packet = expected_q.pop_front();
                compares++;
                if (out_packet !== exp_packet) begin
                    $display("error at %0t: out_packet %h, expected %h",
                             $time, out_packet, exp_packet);
                    errors++;
                end
            end
            stalled     = out_send && !out_ack;
            held_packet = out_packet;

            // the read sees the RAM before this packet's own write
            if (in_send && in_ack) begin
                if (in_packet[MEM_FLAG_BIT]) begin
                    model_rd = model_ram[in_addr][RD_W-1:0];
                end else begin
                    model_rd = const_lookup(in_packet[26:20]);
                end
                if (model_rd !== in_exp_rd) begin
                    $display("error at %0t: read value %h in table, model gives %h",
                             $time, in_exp_rd, model_rd);
                    errors++;
                end
                if (in_wr_e) begin
                    model_ram[in_addr] = in_packet[DATA_W-1:0];
                end
                if (!in_del) begin
                    expected_q.push_back(format_packet(in_packet, model_rd));
                end
            end

            if (done && !done_seen) begin
                done_seen = 1'b1;
                if (expected_q.size() != 0) begin
                    $display("%0d expected packets never reached the output",
                             expected_q.size());
                    errors++;
                end
            end
        end
        queued = expected_q.size();
    end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic CP,
    output logic MR
);

    // period of 4 time units
    initial begin
        CP = 1'b0;
        forever #2 CP = ~CP;
    end

    // reset held over three rising edges, released on a falling edge
    initial begin
        MR = 1'b1;
        repeat (3) @(posedge CP);
        @(negedge CP);
        MR = 1'b0;
    end

endmodule

// File: verification/tb_mmp.sv
module tb_mmp;

    import mmp_pkg::*;

    localparam int ROWS = 24;
    localparam int TIMEOUT_CYCLES = ROWS * 12 + 20;

    logic                 CP;
    logic                 MR;
    logic                 in_send;
    logic                 in_wr_e;
    logic                 in_del;
    logic [ADDR_W-1:0]    in_addr;
    logic [PKT_IN_W-1:0]  in_packet;
    logic [RD_W-1:0]      in_exp_rd;
    logic                 out_ack;
    logic                 in_ack;
    logic                 out_send;
    logic [PKT_OUT_W-1:0] out_packet;
    logic                 done;
    int                   error_count;
    int                   compare_count;
    int                   pending;

    // stimulus and expected read value per row
    logic                 row_send [ROWS];
    logic                 row_wr_e [ROWS];
    logic [ADDR_W-1:0]    row_addr [ROWS];
    logic                 row_del [ROWS];
    logic [PKT_IN_W-1:0]  row_packet [ROWS];
    logic [RD_W-1:0]      row_exp_rd [ROWS];
    int                   row_stall [ROWS];

    integer seed;
    int     stall_left;
    int     drain_left;
    int     cycle_count = 0;

    tb_clock_gen clk_inst (.CP(CP), .MR(MR));

    mmp_top mmp_top_inst (
        .CP         (CP),
        .MR         (MR),
        .in_send    (in_send),
        .in_wr_e    (in_wr_e),
        .in_del     (in_del),
        .in_addr    (in_addr),
        .in_packet  (in_packet),
        .out_ack    (out_ack),
        .in_ack     (in_ack),
        .out_send   (out_send),
        .out_packet (out_packet)
    );

    mmp_checker checker_inst (
        .CP            (CP),
        .MR            (MR),
        .in_send       (in_send),
        .in_ack        (in_ack),
        .in_wr_e       (in_wr_e),
        .in_del        (in_del),
        .in_addr       (in_addr),
        .in_packet     (in_packet),
        .in_exp_rd     (in_exp_rd),
        .out_send      (out_send),
        .out_ack       (out_ack),
        .out_packet    (out_packet),
        .done          (done),
        .error_count   (error_count),
        .compare_count (compare_count),
        .pending       (pending)
    );

    // packet is {lr, tag[9:0], dest, data} with mem_flag at data bit 18
    task automatic set_row(input int idx, input int send, input int wr_e, input int addr,
                           input int del, input int lr, input int tag, input int dest,
                           input int data, input int stall, input int exp_rd);
        row_send[idx]   = send[0];
        row_wr_e[idx]   = wr_e[0];
        row_addr[idx]   = addr[ADDR_W-1:0];
        row_del[idx]    = del[0];
        row_packet[idx] = {lr[0], tag[9:0], dest[6:0], data[19:0]};
        row_stall[idx]  = stall;
        row_exp_rd[idx] = exp_rd[RD_W-1:0];
    endtask

    task automatic fill_table();
        // idx send wr addr del lr tag dest data stall exp_rd
        set_row(0, 1, 0, 5, 0, 1, 'h011, 'h03, 'h40000, 0, 'h0000);
        set_row(1, 1, 0, 0, 0, 0, 'h022, 'h10, 'h12345, 0, 'h0011);
        set_row(2, 1, 1, 5, 0, 1, 'h033, 'h04, 'h4ABCD, 0, 'h0000);
        set_row(3, 1, 0, 5, 0, 1, 'h044, 'h05, 'h40001, 0, 'hABCD);
        set_row(4, 1, 0, 5, 0, 0, 'h055, 'h06, 'h40002, 3, 'hABCD);
        set_row(5, 1, 0, 0, 0, 1, 'h066, 'h7F, 'h00000, 0, 'h0040);
        set_row(6, 1, 0, 0, 0, 0, 'h077, 'h40, 'h2A5A5, 0, 'h0001);
        set_row(7, 0, 0, 0, 0, 0, 'h000, 'h00, 'h00000, 0, 'h0000);
        set_row(8, 1, 1, 9, 1, 0, 'h088, 'h09, 'hC1234, 0, 'h0000);
        set_row(9, 1, 0, 9, 0, 0, 'h099, 'h0A, 'h40000, 2, 'h1234);
        set_row(10, 1, 1, 9, 0, 1, 'h0AA, 'h0B, 'h5FFFF, 0, 'h1234);
        set_row(11, 1, 0, 9, 0, 1, 'h0BB, 'h0C, 'h4000F, 4, 'hFFFF);
        set_row(12, 1, 1, 63, 0, 0, 'h0CC, 'h25, 'h00042, 0, 'h0026);
        set_row(13, 1, 0, 63, 0, 0, 'h0DD, 'h0D, 'h47777, 0, 'h0042);
        set_row(14, 1, 0, 0, 1, 1, 'h0EE, 'h01, 'h00000, 0, 'h0002);
        set_row(15, 1, 0, 0, 0, 1, 'h3FF, 'h3F, 'h3FFFF, 5, 'h0040);
        set_row(16, 0, 0, 0, 0, 0, 'h000, 'h00, 'h00000, 0, 'h0000);
        set_row(17, 1, 1, 0, 0, 0, 'h200, 'h12, 'h7BEEF, 0, 'h0000);
        set_row(18, 1, 0, 0, 0, 1, 'h155, 'h13, 'h40000, 1, 'hBEEF);
        set_row(19, 1, 1, 1, 1, 0, 'h2AA, 'h14, 'h40ABC, 0, 'h0000);
        set_row(20, 1, 1, 1, 1, 1, 'h101, 'h15, 'h4F00D, 0, 'h0ABC);
        set_row(21, 1, 0, 1, 0, 0, 'h1F0, 'h16, 'h40000, 3, 'hF00D);
        set_row(22, 1, 0, 0, 0, 1, 'h0F1, 'h55, 'h80000, 0, 'h0016);
        set_row(23, 1, 0, 5, 0, 0, 'h3C3, 'h17, 'h40000, 2, 'hABCD);
    endtask

    // forced stall cycles come before the random out_ack
    task automatic drive_out_ack();
        if (stall_left > 0) begin
            out_ack = 1'b0;
            stall_left--;
        end else begin
            out_ack = (($random(seed) & 3) != 0);
        end
    endtask

    always @(posedge CP) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d packets still expected",
                     cycle_count, pending);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        in_send = 1'b0;
        in_wr_e = 1'b0;
        in_del = 1'b0;
        in_addr = '0;
        in_packet = '0;
        in_exp_rd = '0;
        out_ack = 1'b0;
        done = 1'b0;
        seed = 29522;
        stall_left = 0;
        drain_left = 0;
        fill_table();
        wait (MR == 1'b0);

        for (int i = 0; i < ROWS; i++) begin
            @(negedge CP);
            stall_left = row_stall[i];
            in_send   = row_send[i];
            in_wr_e   = row_wr_e[i];
            in_addr   = row_addr[i];
            in_del    = row_del[i];
            in_packet = row_packet[i];
            in_exp_rd = row_exp_rd[i];
            drive_out_ack();
            if (row_send[i]) begin
                // hold the row until the entry stage takes it
                @(posedge CP);
                while (!in_ack) begin
                    @(negedge CP);
                    drive_out_ack();
                    @(posedge CP);
                end
            end
        end

        // drain with out_ack held high
        // two packets in flight leave within a few cycles
        @(negedge CP);
        in_send = 1'b0;
        out_ack = 1'b1;
        drain_left = 8;
        while (pending != 0 && drain_left > 0) begin
            @(negedge CP);
            drain_left--;
        end
        repeat (2) @(negedge CP);
        done = 1'b1;
        repeat (2) @(negedge CP);

        $display("%0d packets compared, %0d errors", compare_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
